// ==== logic/side_ch_macros.svh ====
// shared sizes and register indices; counter registers must sit at the top of the 5-bit map
`ifndef SIDE_CH_MACROS_SVH
`define SIDE_CH_MACROS_SVH

// counter sizing
`define SIDE_CH_COUNTER_WIDTH 16
`define SIDE_CH_NUM_COUNTER   6

// raw status inputs from PHY/MAC and gpio
`define SIDE_CH_NUM_SRC       8

// host register port
`define SIDE_CH_ADDR_WIDTH    5
`define SIDE_CH_DATA_WIDTH    32

// register indices
// select holds one 3-bit field per counter, counter 0 in the low bits
`define SIDE_CH_REG_SELECT    1
`define SIDE_CH_REG_INVERT    2 // one bit per raw source

// counters occupy COUNTER0 .. COUNTER0+NUM_COUNTER-1
// a write to any of these clears that counter, write data ignored
`define SIDE_CH_REG_COUNTER0  26

`endif

// ==== logic/side_ch_reg_pkg.sv ====
// host register map types; address and data widths come from side_ch_macros.svh
`default_nettype none

`include "side_ch_macros.svh"

package side_ch_reg_pkg;

	// register address as seen on reg_waddr / reg_raddr
	typedef logic [`SIDE_CH_ADDR_WIDTH-1:0] reg_addr_t;

	// write and read data word
	typedef logic [`SIDE_CH_DATA_WIDTH-1:0] reg_data_t;

	// one event counter, wraps silently
	typedef logic [`SIDE_CH_COUNTER_WIDTH-1:0] count_t;

	// map summary
	//   1      source select, six 3-bit fields
	//   2      invert mask, one bit per raw source
	//   26..31 counter 0..5, read returns count, write clears
	//   other  reads zero, writes ignored

	// first counter register, counter i lives at COUNTER_BASE + i
	localparam int COUNTER_BASE = `SIDE_CH_REG_COUNTER0;

endpackage

`default_nettype wire

// ==== logic/side_ch_event_pkg.sv ====
// raw status source numbering; positions must match the wiring of raw_status at the top
`default_nettype none

`include "side_ch_macros.svh"

package side_ch_event_pkg;

	// index of one raw status source
	typedef logic [$clog2(`SIDE_CH_NUM_SRC)-1:0] src_sel_t;

	// one bit per raw source, used for raw_status and the invert mask
	typedef logic [`SIDE_CH_NUM_SRC-1:0] src_mask_t;

	// positions of the raw status bits
	localparam src_sel_t SRC_PKT_START = 3'd0; // rx packet start
	localparam src_sel_t SRC_FCS_OK    = 3'd1;
	localparam src_sel_t SRC_FCS_FAIL  = 3'd2;
	localparam src_sel_t SRC_TX_START  = 3'd3;
	localparam src_sel_t SRC_TX_DONE   = 3'd4;
	localparam src_sel_t SRC_CCA_BUSY  = 3'd5; // level, high while channel busy
	localparam src_sel_t SRC_GPIO0     = 3'd6; // spare
	localparam src_sel_t SRC_GPIO1     = 3'd7; // spare

	// width of one counter's field inside the select register
	localparam int SEL_FIELD_WIDTH = $bits(src_sel_t);

endpackage

`default_nettype wire

// ==== logic/side_ch_event_route.sv ====
// per-counter source select and invert, one register stage; raw inputs assumed slow levels
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_macros.svh"

module side_ch_event_route (
	input  wire                                clk,
	input  wire                                reset,
	input  side_ch_event_pkg::src_mask_t       raw_status,
	input  wire [`SIDE_CH_NUM_COUNTER*side_ch_event_pkg::SEL_FIELD_WIDTH-1:0] src_select,
	input  side_ch_event_pkg::src_mask_t       src_invert,
	output logic                               event0,
	output logic                               event1,
	output logic                               event2,
	output logic                               event3,
	output logic                               event4,
	output logic                               event5
);

	localparam int SEL_W = side_ch_event_pkg::SEL_FIELD_WIDTH;

	logic [`SIDE_CH_NUM_COUNTER-1:0] event_d; // routed level before the register
	logic [`SIDE_CH_NUM_COUNTER-1:0] event_q;

	// pick the selected raw bit and apply that source's invert bit
	for (genvar i = 0; i < `SIDE_CH_NUM_COUNTER; i++) begin : g_route
		side_ch_event_pkg::src_sel_t sel;

		assign sel = src_select[i*SEL_W +: SEL_W];
		assign event_d[i] = raw_status[sel] ^ src_invert[sel];
	end

	// the register also breaks the path from the status sources into the edge detectors
	always_ff @(posedge clk) begin
		if (reset) begin
			event_q <= '0;
		end else begin
			event_q <= event_d;
		end
	end

	assign event0 = event_q[0];
	assign event1 = event_q[1];
	assign event2 = event_q[2];
	assign event3 = event_q[3];
	assign event4 = event_q[4];
	assign event5 = event_q[5];

endmodule

`default_nettype wire

// ==== logic/side_ch_counter.sv ====
// six rising-edge counters, wrap at 2^16; a level held high across a clear is counted again
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_macros.svh"

module side_ch_counter (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       reg_wren,
	input  side_ch_reg_pkg::reg_addr_t reg_waddr,
	input  wire                       event0,
	input  wire                       event1,
	input  wire                       event2,
	input  wire                       event3,
	input  wire                       event4,
	input  wire                       event5,
	output side_ch_reg_pkg::count_t   counter0,
	output side_ch_reg_pkg::count_t   counter1,
	output side_ch_reg_pkg::count_t   counter2,
	output side_ch_reg_pkg::count_t   counter3,
	output side_ch_reg_pkg::count_t   counter4,
	output side_ch_reg_pkg::count_t   counter5
);

	logic [`SIDE_CH_NUM_COUNTER-1:0] clr; // host write to the counter's own address

	// delayed event copies for edge detection
	logic event0_q;
	logic event1_q;
	logic event2_q;
	logic event3_q;
	logic event4_q;
	logic event5_q;

	for (genvar i = 0; i < `SIDE_CH_NUM_COUNTER; i++) begin : g_clr
		assign clr[i] = reg_wren &&
			(reg_waddr == side_ch_reg_pkg::reg_addr_t'(side_ch_reg_pkg::COUNTER_BASE + i));
	end

	always_ff @(posedge clk) begin
		if (reset || clr[0]) begin
			counter0 <= '0;
			event0_q <= 1'b0; // copy cleared too, so a high level counts again
		end else begin
			event0_q <= event0;
			if (event0 && !event0_q) counter0 <= counter0 + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clr[1]) begin
			counter1 <= '0;
			event1_q <= 1'b0;
		end else begin
			event1_q <= event1;
			if (event1 && !event1_q) counter1 <= counter1 + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clr[2]) begin
			counter2 <= '0;
			event2_q <= 1'b0;
		end else begin
			event2_q <= event2;
			if (event2 && !event2_q) counter2 <= counter2 + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clr[3]) begin
			counter3 <= '0;
			event3_q <= 1'b0;
		end else begin
			event3_q <= event3;
			if (event3 && !event3_q) counter3 <= counter3 + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clr[4]) begin
			counter4 <= '0;
			event4_q <= 1'b0;
		end else begin
			event4_q <= event4;
			if (event4 && !event4_q) counter4 <= counter4 + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clr[5]) begin
			counter5 <= '0;
			event5_q <= 1'b0;
		end else begin
			event5_q <= event5;
			if (event5 && !event5_q) counter5 <= counter5 + 1'b1; // wraps at 2^16
		end
	end

endmodule

`default_nettype wire

// ==== logic/side_ch_regs.sv ====
// config registers and registered read mux; counter writes are decoded in side_ch_counter
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_macros.svh"

module side_ch_regs (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        reg_wren,
	input  side_ch_reg_pkg::reg_addr_t reg_waddr,
	input  side_ch_reg_pkg::reg_data_t reg_wdata,
	input  side_ch_reg_pkg::reg_addr_t reg_raddr,
	input  side_ch_reg_pkg::count_t    counter0,
	input  side_ch_reg_pkg::count_t    counter1,
	input  side_ch_reg_pkg::count_t    counter2,
	input  side_ch_reg_pkg::count_t    counter3,
	input  side_ch_reg_pkg::count_t    counter4,
	input  side_ch_reg_pkg::count_t    counter5,
	output side_ch_reg_pkg::reg_data_t reg_rdata,
	output logic [`SIDE_CH_NUM_COUNTER*side_ch_event_pkg::SEL_FIELD_WIDTH-1:0] src_select,
	output side_ch_event_pkg::src_mask_t src_invert
);

	localparam side_ch_reg_pkg::reg_addr_t ADDR_SELECT =
		side_ch_reg_pkg::reg_addr_t'(`SIDE_CH_REG_SELECT);
	localparam side_ch_reg_pkg::reg_addr_t ADDR_INVERT =
		side_ch_reg_pkg::reg_addr_t'(`SIDE_CH_REG_INVERT);
	localparam side_ch_reg_pkg::reg_addr_t ADDR_CNT0 =
		side_ch_reg_pkg::reg_addr_t'(side_ch_reg_pkg::COUNTER_BASE);

	// configuration writes, upper data bits dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			// every counter watches packet start by default
			src_select <= {`SIDE_CH_NUM_COUNTER{side_ch_event_pkg::SRC_PKT_START}};
			src_invert <= '0;
		end else if (reg_wren) begin
			case (reg_waddr)
				ADDR_SELECT: src_select <= reg_wdata[$bits(src_select)-1:0];
				ADDR_INVERT: src_invert <= side_ch_event_pkg::src_mask_t'(reg_wdata);
				default: ; // counter clears and unmapped addresses
			endcase
		end
	end

	// read data one edge after the address, zero-extended to the bus
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_rdata <= '0;
		end else begin
			case (reg_raddr)
				ADDR_SELECT:      reg_rdata <= side_ch_reg_pkg::reg_data_t'(src_select);
				ADDR_INVERT:      reg_rdata <= side_ch_reg_pkg::reg_data_t'(src_invert);
				ADDR_CNT0:        reg_rdata <= side_ch_reg_pkg::reg_data_t'(counter0);
				ADDR_CNT0 + 5'd1: reg_rdata <= side_ch_reg_pkg::reg_data_t'(counter1);
				ADDR_CNT0 + 5'd2: reg_rdata <= side_ch_reg_pkg::reg_data_t'(counter2);
				ADDR_CNT0 + 5'd3: reg_rdata <= side_ch_reg_pkg::reg_data_t'(counter3);
				ADDR_CNT0 + 5'd4: reg_rdata <= side_ch_reg_pkg::reg_data_t'(counter4);
				ADDR_CNT0 + 5'd5: reg_rdata <= side_ch_reg_pkg::reg_data_t'(counter5);
				default:          reg_rdata <= '0; // unmapped
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/side_ch_top.sv ====
// statistics block top; raw_status to reg_rdata takes 3 edges when reg_raddr is already set
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_macros.svh"

module side_ch_top (
	input  wire                          clk,
	input  wire                          reset,
	input  side_ch_event_pkg::src_mask_t raw_status,
	input  wire                          reg_wren, // one-cycle strobe, always accepted
	input  side_ch_reg_pkg::reg_addr_t   reg_waddr,
	input  side_ch_reg_pkg::reg_data_t   reg_wdata,
	input  side_ch_reg_pkg::reg_addr_t   reg_raddr, // level
	output side_ch_reg_pkg::reg_data_t   reg_rdata
);

	logic [`SIDE_CH_NUM_COUNTER*side_ch_event_pkg::SEL_FIELD_WIDTH-1:0] src_select;
	side_ch_event_pkg::src_mask_t src_invert;

	logic event0, event1, event2, event3, event4, event5;

	side_ch_reg_pkg::count_t counter0, counter1, counter2;
	side_ch_reg_pkg::count_t counter3, counter4, counter5;

	side_ch_event_route u_route (
		.clk       (clk),
		.reset     (reset),
		.raw_status(raw_status),
		.src_select(src_select),
		.src_invert(src_invert),
		.event0    (event0),
		.event1    (event1),
		.event2    (event2),
		.event3    (event3),
		.event4    (event4),
		.event5    (event5)
	);

	// decodes its own clear addresses from the write port
	side_ch_counter u_counter (
		.clk      (clk),
		.reset    (reset),
		.reg_wren (reg_wren),
		.reg_waddr(reg_waddr),
		.event0   (event0),
		.event1   (event1),
		.event2   (event2),
		.event3   (event3),
		.event4   (event4),
		.event5   (event5),
		.counter0 (counter0),
		.counter1 (counter1),
		.counter2 (counter2),
		.counter3 (counter3),
		.counter4 (counter4),
		.counter5 (counter5)
	);

	side_ch_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.reg_wren  (reg_wren),
		.reg_waddr (reg_waddr),
		.reg_wdata (reg_wdata),
		.reg_raddr (reg_raddr),
		.counter0  (counter0),
		.counter1  (counter1),
		.counter2  (counter2),
		.counter3  (counter3),
		.counter4  (counter4),
		.counter5  (counter5),
		.reg_rdata (reg_rdata),
		.src_select(src_select),
		.src_invert(src_invert)
	);

endmodule

`default_nettype wire

// ==== tb/side_ch_tb.sv ====
// self-checking testbench for side_ch_top; stimulus holds each raw value 4 cycles so no edges merge
`timescale 1ns/1ps
`default_nettype none

`include "side_ch_macros.svh"

module side_ch_tb;

	localparam int SEL_W = `SIDE_CH_NUM_COUNTER * side_ch_event_pkg::SEL_FIELD_WIDTH;
	localparam int CYCLE_LIMIT = 6000; // about 260 steps of 4 cycles plus reads and writes

	logic clk;
	logic reset;
	side_ch_event_pkg::src_mask_t raw_status;
	logic reg_wren;
	side_ch_reg_pkg::reg_addr_t reg_waddr;
	side_ch_reg_pkg::reg_data_t reg_wdata;
	side_ch_reg_pkg::reg_addr_t reg_raddr;
	side_ch_reg_pkg::reg_data_t reg_rdata;

	// model of what the DUT should hold
	logic [SEL_W-1:0] sel_cfg;
	side_ch_event_pkg::src_mask_t inv_cfg;
	logic [`SIDE_CH_NUM_COUNTER-1:0] prev_eff;
	side_ch_reg_pkg::count_t exp_count [`SIDE_CH_NUM_COUNTER];

	logic [15:0] lfsr_state;
	logic check_req; // main flow asks the checker to read all counters
	int fail_count;
	int cycle_count;

	side_ch_top i_side_ch_top (
		.clk       (clk),
		.reset     (reset),
		.raw_status(raw_status),
		.reg_wren  (reg_wren),
		.reg_waddr (reg_waddr),
		.reg_wdata (reg_wdata),
		.reg_raddr (reg_raddr),
		.reg_rdata (reg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r[k] = lfsr_state[0]; // one step per bit
		end
		return r;
	endfunction

	// expected count after one sample of the routed level
	function automatic side_ch_reg_pkg::count_t ref_count(input logic prev, input logic cur,
			input side_ch_reg_pkg::count_t count);
		if (!prev && cur)
			return count + 1'b1; // wraps at 2^16
		return count;
	endfunction

	// selected raw bit xor the invert bit of that source
	function automatic logic eff_level(input int i);
		int src;
		src = sel_cfg[i*side_ch_event_pkg::SEL_FIELD_WIDTH +: side_ch_event_pkg::SEL_FIELD_WIDTH];
		return raw_status[src] ^ inv_cfg[src];
	endfunction

	task automatic update_model();
		logic cur;
		for (int i = 0; i < `SIDE_CH_NUM_COUNTER; i++) begin
			cur = eff_level(i);
			exp_count[i] = ref_count(prev_eff[i], cur, exp_count[i]);
			prev_eff[i] = cur;
		end
	endtask

	task automatic compare(input side_ch_reg_pkg::reg_data_t actual,
			input side_ch_reg_pkg::reg_data_t expected, input string msg);
		if (actual !== expected) begin
			fail_count++;
			$display("FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic read_reg(input int addr, output side_ch_reg_pkg::reg_data_t data);
		@(negedge clk);
		reg_raddr = side_ch_reg_pkg::reg_addr_t'(addr);
		@(negedge clk); // rdata registered on the edge in between
		data = reg_rdata;
	endtask

	// strobe for one cycle, then idle so a config change settles before the next step
	task automatic write_reg(input int addr, input side_ch_reg_pkg::reg_data_t data);
		@(negedge clk);
		reg_wren = 1'b1;
		reg_waddr = side_ch_reg_pkg::reg_addr_t'(addr);
		reg_wdata = data;
		@(negedge clk);
		reg_wren = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic step_raw(input side_ch_event_pkg::src_mask_t toggle);
		@(negedge clk);
		raw_status = raw_status ^ toggle;
		update_model();
		repeat (3) @(negedge clk);
	endtask

	task automatic run_checks();
		check_req = 1'b1;
		wait (!check_req);
	endtask

	// checker process, reads every counter and compares with the model
	initial begin
		side_ch_reg_pkg::reg_data_t data;
		forever begin
			wait (check_req);
			for (int i = 0; i < `SIDE_CH_NUM_COUNTER; i++) begin
				read_reg(`SIDE_CH_REG_COUNTER0 + i, data);
				compare(data, side_ch_reg_pkg::reg_data_t'(exp_count[i]),
					$sformatf("counter %0d", i));
			end
			check_req = 1'b0;
		end
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= CYCLE_LIMIT) begin
				$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
				$display("TEST RESULT: FAIL");
				$fatal(1, "timeout");
			end
		end
	end

	initial begin
		side_ch_reg_pkg::reg_data_t data;
		side_ch_reg_pkg::reg_data_t wval;
		int idx;
		reset = 1'b1;
		raw_status = '0;
		reg_wren = 1'b0;
		reg_waddr = '0;
		reg_wdata = '0;
		reg_raddr = '0;
		check_req = 1'b0;
		fail_count = 0;
		lfsr_state = 16'd3923;
		sel_cfg = '0;
		inv_cfg = '0;
		prev_eff = '0;
		for (int i = 0; i < `SIDE_CH_NUM_COUNTER; i++)
			exp_count[i] = '0;
		repeat (3) @(posedge clk); // three reset edges
		@(negedge clk);
		reset = 1'b0;

		// everything reads zero after reset, unmapped addresses too
		read_reg(`SIDE_CH_REG_SELECT, data);
		compare(data, '0, "select after reset");
		read_reg(`SIDE_CH_REG_INVERT, data);
		compare(data, '0, "invert after reset");
		read_reg(0, data);
		compare(data, '0, "unmapped address 0");
		read_reg(17, data);
		compare(data, '0, "unmapped address 17");
		run_checks();

		// readback is masked to the field widths
		wval = take_bits(32);
		write_reg(`SIDE_CH_REG_SELECT, wval);
		sel_cfg = wval[SEL_W-1:0];
		update_model();
		read_reg(`SIDE_CH_REG_SELECT, data);
		compare(data, {14'd0, wval[17:0]}, "select readback");
		wval = take_bits(32);
		write_reg(`SIDE_CH_REG_INVERT, wval);
		inv_cfg = wval[7:0];
		update_model();
		read_reg(`SIDE_CH_REG_INVERT, data);
		compare(data, {24'd0, wval[7:0]}, "invert readback");
		run_checks();

		// back to default routing, all counters on packet start
		write_reg(`SIDE_CH_REG_SELECT, '0);
		sel_cfg = '0;
		update_model();
		write_reg(`SIDE_CH_REG_INVERT, '0);
		inv_cfg = '0;
		update_model();
		run_checks();
		for (int g = 0; g < 16; g++) begin
			for (int s = 0; s < 5; s++)
				step_raw(side_ch_event_pkg::src_mask_t'(take_bits(1)));
			run_checks();
		end

		// random routing and inversion
		for (int c = 0; c < 6; c++) begin
			wval = take_bits(32);
			write_reg(`SIDE_CH_REG_SELECT, wval);
			sel_cfg = wval[SEL_W-1:0];
			update_model();
			wval = take_bits(32);
			write_reg(`SIDE_CH_REG_INVERT, wval);
			inv_cfg = wval[7:0];
			update_model();
			for (int g = 0; g < 5; g++) begin
				for (int s = 0; s < 5; s++)
					step_raw(side_ch_event_pkg::src_mask_t'(take_bits(8)));
				run_checks();
			end
		end

		// clear one counter while its routed level is low
		for (int r = 0; r < 6; r++) begin
			for (int s = 0; s < 5; s++)
				step_raw(side_ch_event_pkg::src_mask_t'(take_bits(8)));
			run_checks();
			idx = r;
			for (int k = 0; k < `SIDE_CH_NUM_COUNTER && prev_eff[idx]; k++)
				idx = (idx + 1) % `SIDE_CH_NUM_COUNTER;
			if (!prev_eff[idx]) begin
				write_reg(`SIDE_CH_REG_COUNTER0 + idx, take_bits(32));
				exp_count[idx] = '0;
				run_checks();
			end
		end

		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/side_ch_reg_pkg.sv
logic/side_ch_event_pkg.sv
logic/side_ch_event_route.sv
logic/side_ch_counter.sv
logic/side_ch_regs.sv
logic/side_ch_top.sv
tb/side_ch_tb.sv
